// File: source/stbuf_cfg_pkg.sv
// memory word and address geometry; byte lanes are 8 bits and BYTE_WIDTH must equal 2**OFFS_WIDTH
package stbuf_cfg_pkg;

   //----------------------------------------------------------------------
   // memory word
   //----------------------------------------------------------------------
   localparam int DATA_WIDTH = 32;               // bits per memory word
   localparam int BYTE_WIDTH = DATA_WIDTH / 8;   // byte lanes per word

   //----------------------------------------------------------------------
   // address
   //----------------------------------------------------------------------
   localparam int ADDR_WIDTH = 16;               // byte address
   localparam int OFFS_WIDTH = $clog2(BYTE_WIDTH); // byte select within word

endpackage

// File: source/stbuf_types_pkg.sv
// access size encoding and the store word seen as one vector or as byte lanes; no 3-byte or dword size
package stbuf_types_pkg;
   import stbuf_cfg_pkg::*;

   // size of a load/store access, naturally aligned
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_e;

   // one memory word, read whole or lane by lane
   typedef union packed {
      logic [DATA_WIDTH-1:0]       word;    // full word view
      logic [BYTE_WIDTH-1:0][7:0]  lanes;   // lane 0 is the low byte
   } stbuf_word_u;

endpackage

// File: source/stbuf_write_stage.sv
// dc3 write side; stores must be naturally aligned and the core must hold off st_dc1 while full is high
`timescale 1ns/100ps

module stbuf_write_stage
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         st_dc1,
   input  logic                         st_dc2,
   input  logic                         st_dc3,
   input  logic [ADDR_WIDTH-1:0]        st_addr,
   input  access_size_e                 st_size,
   input  logic [DATA_WIDTH-1:0]        st_data,      // right-aligned
   input  logic [$clog2(DEPTH+1)-1:0]   entry_count,
   output logic                         wr_en,
   output logic [$clog2(DEPTH)-1:0]     wr_ptr,
   output logic [BYTE_WIDTH-1:0]        wr_byteen,
   output stbuf_word_u                  wr_data,
   output logic                         full
);

   localparam int PTR_WIDTH = $clog2(DEPTH);
   localparam int CNT_WIDTH = $clog2(DEPTH+1);
   localparam int SPEC_WIDTH = CNT_WIDTH + 2;     // count plus three pipe stages

   logic [BYTE_WIDTH-1:0]  size_mask;
   logic [OFFS_WIDTH-1:0]  offs;
   stbuf_word_u            st_word;
   logic [SPEC_WIDTH-1:0]  spec_count;

   //----------------------------------------------------------------------
   // byte enables and lane alignment
   //----------------------------------------------------------------------
   always_comb begin
      case (st_size)
         size_byte: size_mask = BYTE_WIDTH'(1);
         size_half: size_mask = BYTE_WIDTH'(3);
         default:   size_mask = '1;
      endcase
   end

   assign offs      = st_addr[OFFS_WIDTH-1:0];
   assign wr_byteen = size_mask << offs;
   assign st_word.word = st_data;

   // move each source byte up by the address offset, unused lanes stay 0
   always_comb begin
      wr_data = '0;
      for (int i = 0; i < BYTE_WIDTH; i++) begin
         if (wr_byteen[i]) begin
            wr_data.lanes[i] = st_word.lanes[OFFS_WIDTH'(i - int'(offs))];
         end
      end
   end

   assign wr_en = st_dc3;

   //----------------------------------------------------------------------
   // write pointer and speculative full
   //----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (st_dc3) begin
         wr_ptr <= wr_ptr + PTR_WIDTH'(1);
      end
   end

   // stores already past dc1 still need a slot
   assign spec_count = SPEC_WIDTH'(entry_count) + SPEC_WIDTH'(st_dc1) +
                       SPEC_WIDTH'(st_dc2) + SPEC_WIDTH'(st_dc3);
   assign full = (spec_count >= SPEC_WIDTH'(DEPTH));

   // full at dc1 should have kept every slot free by dc3
   a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      st_dc3 |-> (entry_count != CNT_WIDTH'(DEPTH)));

   a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      st_dc3 |-> ((st_size == size_byte) ||
                  ((st_size == size_half) && !st_addr[0]) ||
                  ((st_size == size_word) && (st_addr[OFFS_WIDTH-1:0] == '0))));

endmodule

// File: source/stbuf_resolve_pipe.sv
// carries a dc3 write to dc5; commit_dc5 is only looked at when the written store sits in dc5
`timescale 1ns/100ps

module stbuf_resolve_pipe #(
   parameter int DEPTH = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       wr_en,
   input  logic [$clog2(DEPTH)-1:0]   wr_ptr,
   input  logic                       commit_dc5,
   output logic                       mark_en,
   output logic [$clog2(DEPTH)-1:0]   mark_ptr,
   output logic                       mark_commit
);

   localparam int PTR_WIDTH = $clog2(DEPTH);

   logic                  wr_en_dc4;
   logic                  wr_en_dc5;
   logic [PTR_WIDTH-1:0]  wr_ptr_dc4;
   logic [PTR_WIDTH-1:0]  wr_ptr_dc5;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_en_dc4 <= 1'b0;
         wr_en_dc5 <= 1'b0;
      end else begin
         wr_en_dc4 <= wr_en;
         wr_en_dc5 <= wr_en_dc4;
      end
   end

   // entry index follows the strobe
   always_ff @(posedge clk) begin
      wr_ptr_dc4 <= wr_ptr;
      wr_ptr_dc5 <= wr_ptr_dc4;
   end

   assign mark_en     = wr_en_dc5;
   assign mark_ptr    = wr_ptr_dc5;
   assign mark_commit = wr_en_dc5 & commit_dc5;   // 0 with mark_en means flush

endmodule

// File: source/stbuf_entry_array.sv
// entry storage and in-order drain; drain_ack must only come while drain_vld is high
`timescale 1ns/100ps

module stbuf_entry_array
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               wr_en,
   input  logic [$clog2(DEPTH)-1:0]           wr_ptr,
   input  logic [ADDR_WIDTH-1:0]              wr_addr,
   input  logic [BYTE_WIDTH-1:0]              wr_byteen,
   input  stbuf_word_u                        wr_data,
   input  logic                               mark_en,
   input  logic [$clog2(DEPTH)-1:0]           mark_ptr,
   input  logic                               mark_commit,
   input  logic                               drain_ack,
   output logic                               drain_vld,
   output logic [ADDR_WIDTH-1:0]              drain_addr,
   output logic [BYTE_WIDTH-1:0]              drain_byteen,
   output logic [DATA_WIDTH-1:0]              drain_data,
   output logic [$clog2(DEPTH+1)-1:0]         entry_count,
   output logic                               empty,
   output logic [DEPTH-1:0]                   ent_live,
   output logic [DEPTH-1:0][ADDR_WIDTH-1:0]   ent_addr,
   output logic [DEPTH-1:0][BYTE_WIDTH-1:0]   ent_byteen,
   output stbuf_word_u [DEPTH-1:0]            ent_data
);

   localparam int PTR_WIDTH = $clog2(DEPTH);
   localparam int CNT_WIDTH = $clog2(DEPTH+1);

   logic [DEPTH-1:0]                  data_vld;      // entry written
   logic [DEPTH-1:0]                  drain_vld_q;   // committed, may drain
   logic [DEPTH-1:0]                  flush_vld_q;   // killed, drop at head
   logic [DEPTH-1:0][ADDR_WIDTH-1:0]  addr_q;
   logic [DEPTH-1:0][BYTE_WIDTH-1:0]  byteen_q;
   stbuf_word_u [DEPTH-1:0]           data_q;
   logic [PTR_WIDTH-1:0]              rd_ptr;
   logic                              head_flushed;
   logic                              pop;

   assign head_flushed = flush_vld_q[rd_ptr];
   assign pop          = drain_ack | head_flushed;

   //----------------------------------------------------------------------
   // entry state and read pointer
   //----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         data_vld    <= '0;
         drain_vld_q <= '0;
         flush_vld_q <= '0;
         rd_ptr      <= '0;
      end else begin
         if (pop) begin
            data_vld[rd_ptr]    <= 1'b0;
            drain_vld_q[rd_ptr] <= 1'b0;
            flush_vld_q[rd_ptr] <= 1'b0;
            rd_ptr              <= rd_ptr + PTR_WIDTH'(1);
         end
         if (wr_en) begin
            data_vld[wr_ptr] <= 1'b1;
         end
         // dc5 resolution of an entry written two cycles ago
         if (mark_en) begin
            drain_vld_q[mark_ptr] <= mark_commit;
            flush_vld_q[mark_ptr] <= !mark_commit;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         addr_q[wr_ptr]   <= wr_addr;
         byteen_q[wr_ptr] <= wr_byteen;
         data_q[wr_ptr]   <= wr_data;
      end
   end

   //----------------------------------------------------------------------
   // head and status
   //----------------------------------------------------------------------
   assign drain_vld    = drain_vld_q[rd_ptr];   // held until drain_ack
   assign drain_addr   = addr_q[rd_ptr];
   assign drain_byteen = byteen_q[rd_ptr];
   assign drain_data   = data_q[rd_ptr].word;

   always_comb begin
      entry_count = '0;
      for (int i = 0; i < DEPTH; i++) begin
         entry_count = entry_count + CNT_WIDTH'(data_vld[i]);
      end
   end

   assign empty      = ~|data_vld;
   assign ent_live   = data_vld & ~flush_vld_q;   // candidates for forwarding
   assign ent_addr   = addr_q;
   assign ent_byteen = byteen_q;
   assign ent_data   = data_q;

   a_drain_flush_excl: assert property (@(posedge clk) disable iff (!rst_n)
      (drain_vld_q & flush_vld_q) == '0);

   // a mark must land on an entry the write side filled two cycles earlier
   a_mark_on_valid: assert property (@(posedge clk) disable iff (!rst_n)
      ((drain_vld_q | flush_vld_q) & ~data_vld) == '0);

   a_ack_with_vld: assert property (@(posedge clk) disable iff (!rst_n)
      drain_ack |-> drain_vld);

endmodule

// File: source/stbuf_load_forward.sv
// dc2 load forwarding from written entries only; a store in dc3 in the same cycle is not seen
`timescale 1ns/100ps

module stbuf_load_forward
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               ld_dc2,
   input  logic [ADDR_WIDTH-1:0]              ld_addr,
   input  logic [$clog2(DEPTH)-1:0]           wr_ptr,
   input  logic [DEPTH-1:0]                   ent_live,
   input  logic [DEPTH-1:0][ADDR_WIDTH-1:0]   ent_addr,
   input  logic [DEPTH-1:0][BYTE_WIDTH-1:0]   ent_byteen,
   input  stbuf_word_u [DEPTH-1:0]            ent_data,
   output logic [BYTE_WIDTH-1:0]              fwd_byteen,
   output stbuf_word_u                        fwd_data
);

   localparam int PTR_WIDTH = $clog2(DEPTH);

   logic [DEPTH-1:0]       ld_match;
   logic [BYTE_WIDTH-1:0]  byteen_dc2;
   stbuf_word_u            data_dc2;

   // word address compare, byte offset ignored
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         ld_match[i] = ent_live[i] &&
                       (ent_addr[i][ADDR_WIDTH-1:OFFS_WIDTH] == ld_addr[ADDR_WIDTH-1:OFFS_WIDTH]);
      end
   end

   //----------------------------------------------------------------------
   // byte merge, oldest first so the youngest store wins
   //----------------------------------------------------------------------
   always_comb begin
      logic [PTR_WIDTH-1:0] idx;
      byteen_dc2 = '0;
      data_dc2   = '0;
      for (int k = 0; k < DEPTH; k++) begin
         idx = wr_ptr + PTR_WIDTH'(k);   // wr_ptr slot is free or the oldest
         for (int j = 0; j < BYTE_WIDTH; j++) begin
            if (ld_match[idx] && ent_byteen[idx][j]) begin
               byteen_dc2[j]     = 1'b1;
               data_dc2.lanes[j] = ent_data[idx].lanes[j];
            end
         end
      end
   end

   // dc3 result
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fwd_byteen <= '0;
      end else begin
         fwd_byteen <= ld_dc2 ? byteen_dc2 : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_dc2) begin
         fwd_data <= data_dc2;   // lanes without a match are 0
      end
   end

endmodule

// File: source/stbuf_top.sv
// store buffer top; DEPTH must be a power of two and at least 2, unaligned and dual stores unsupported
`timescale 1ns/100ps

module stbuf_top
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    st_dc1,
   input  logic                    st_dc2,
   input  logic                    st_dc3,
   input  logic [ADDR_WIDTH-1:0]   st_addr,
   input  access_size_e            st_size,
   input  logic [DATA_WIDTH-1:0]   st_data,
   input  logic                    commit_dc5,
   input  logic                    ld_dc2,
   input  logic [ADDR_WIDTH-1:0]   ld_addr,
   input  logic                    drain_ack,
   output logic                    drain_vld,
   output logic [ADDR_WIDTH-1:0]   drain_addr,
   output logic [BYTE_WIDTH-1:0]   drain_byteen,
   output logic [DATA_WIDTH-1:0]   drain_data,
   output logic                    full,
   output logic                    empty,
   output logic [BYTE_WIDTH-1:0]   fwd_byteen,
   output stbuf_word_u             fwd_data
);

   localparam int PTR_WIDTH = $clog2(DEPTH);
   localparam int CNT_WIDTH = $clog2(DEPTH+1);

   // write side
   logic                              wr_en;
   logic [PTR_WIDTH-1:0]              wr_ptr;
   logic [BYTE_WIDTH-1:0]             wr_byteen;
   stbuf_word_u                       wr_data;
   logic [CNT_WIDTH-1:0]              entry_count;

   // dc5 resolution
   logic                              mark_en;
   logic [PTR_WIDTH-1:0]              mark_ptr;
   logic                              mark_commit;

   // entry view for forwarding
   logic [DEPTH-1:0]                  ent_live;
   logic [DEPTH-1:0][ADDR_WIDTH-1:0]  ent_addr;
   logic [DEPTH-1:0][BYTE_WIDTH-1:0]  ent_byteen;
   stbuf_word_u [DEPTH-1:0]           ent_data;

   stbuf_write_stage #(.DEPTH(DEPTH)) write_stage_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .st_dc1      (st_dc1),
      .st_dc2      (st_dc2),
      .st_dc3      (st_dc3),
      .st_addr     (st_addr),
      .st_size     (st_size),
      .st_data     (st_data),
      .entry_count (entry_count),
      .wr_en       (wr_en),
      .wr_ptr      (wr_ptr),
      .wr_byteen   (wr_byteen),
      .wr_data     (wr_data),
      .full        (full)
   );

   stbuf_resolve_pipe #(.DEPTH(DEPTH)) resolve_pipe_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_en       (wr_en),
      .wr_ptr      (wr_ptr),
      .commit_dc5  (commit_dc5),
      .mark_en     (mark_en),
      .mark_ptr    (mark_ptr),
      .mark_commit (mark_commit)
   );

   stbuf_entry_array #(.DEPTH(DEPTH)) entry_array_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr_en        (wr_en),
      .wr_ptr       (wr_ptr),
      .wr_addr      (st_addr),
      .wr_byteen    (wr_byteen),
      .wr_data      (wr_data),
      .mark_en      (mark_en),
      .mark_ptr     (mark_ptr),
      .mark_commit  (mark_commit),
      .drain_ack    (drain_ack),
      .drain_vld    (drain_vld),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data),
      .entry_count  (entry_count),
      .empty        (empty),
      .ent_live     (ent_live),
      .ent_addr     (ent_addr),
      .ent_byteen   (ent_byteen),
      .ent_data     (ent_data)
   );

   stbuf_load_forward #(.DEPTH(DEPTH)) load_forward_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .ld_dc2     (ld_dc2),
      .ld_addr    (ld_addr),
      .wr_ptr     (wr_ptr),
      .ent_live   (ent_live),
      .ent_addr   (ent_addr),
      .ent_byteen (ent_byteen),
      .ent_data   (ent_data),
      .fwd_byteen (fwd_byteen),
      .fwd_data   (fwd_data)
   );

endmodule

// File: include/stbuf_tb_tasks.svh
// included inside stbuf_tb only; relies on clk from the enclosing module
`ifndef STBUF_TB_TASKS_SVH
`define STBUF_TB_TASKS_SVH

   //----------------------------------------------------------------------
   // failure exit
   //----------------------------------------------------------------------
   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   //----------------------------------------------------------------------
   // value compare
   //----------------------------------------------------------------------
   task automatic check_value(input string        name,
                              input logic [63:0]  actual,
                              input logic [63:0]  expected);
      if (actual !== expected) begin
         stop_run($sformatf("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                            $time, name, actual, expected));
      end
   endtask

   // run length guard, counted in clock cycles
   task automatic watch_timeout(input int unsigned cycles);
      repeat (cycles) @(posedge clk);
      stop_run($sformatf("timeout: the run did not finish within %0d cycles", cycles));
   endtask

`endif

// File: test/stbuf_tb.sv
// random traffic test of stbuf_top with DEPTH 4; stores stay in a few words so loads often forward
`timescale 1ns/100ps

module stbuf_tb
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
();

   localparam int          DEPTH      = 4;
   localparam int          OP_COUNT   = 3000;     // traffic cycles
   localparam int unsigned SEED       = 32'h508;
   localparam int          CLK_PERIOD = 4;        // ns

   localparam int ST_PENDING = 0;   // written, dc5 not reached yet
   localparam int ST_COMMIT  = 1;
   localparam int ST_FLUSH   = 2;

   logic                   clk;
   logic                   rst_n;
   logic                   st_dc1;
   logic                   st_dc2;
   logic                   st_dc3;
   logic [ADDR_WIDTH-1:0]  st_addr;
   access_size_e           st_size;
   logic [DATA_WIDTH-1:0]  st_data;
   logic                   commit_dc5;
   logic                   ld_dc2;
   logic [ADDR_WIDTH-1:0]  ld_addr;
   logic                   drain_ack;
   logic                   drain_vld;
   logic [ADDR_WIDTH-1:0]  drain_addr;
   logic [BYTE_WIDTH-1:0]  drain_byteen;
   logic [DATA_WIDTH-1:0]  drain_data;
   logic                   full;
   logic                   empty;
   logic [BYTE_WIDTH-1:0]  fwd_byteen;
   stbuf_word_u            fwd_data;

   // model entries in program order, index 0 is the head
   int unsigned            m_id[$];
   logic [ADDR_WIDTH-1:0]  m_addr[$];
   logic [BYTE_WIDTH-1:0]  m_byteen[$];
   logic [DATA_WIDTH-1:0]  m_data[$];
   int                     m_state[$];

   int unsigned            next_id;
   logic                   dc4_vld;
   int unsigned            dc4_id;
   logic                   dc5_vld;
   int unsigned            dc5_id;
   logic                   traffic_on;

   // expectations for the following cycle
   logic                   ld_pending;
   logic [BYTE_WIDTH-1:0]  exp_fwd_byteen;
   logic [DATA_WIDTH-1:0]  exp_fwd_data;
   logic                   hold_pending;      // head stalled by memory
   logic [ADDR_WIDTH-1:0]  hold_addr;
   logic [BYTE_WIDTH-1:0]  hold_byteen;
   logic [DATA_WIDTH-1:0]  hold_data;

   `include "stbuf_tb_tasks.svh"

   stbuf_top #(.DEPTH(DEPTH)) stbuf_top_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .st_dc1       (st_dc1),
      .st_dc2       (st_dc2),
      .st_dc3       (st_dc3),
      .st_addr      (st_addr),
      .st_size      (st_size),
      .st_data      (st_data),
      .commit_dc5   (commit_dc5),
      .ld_dc2       (ld_dc2),
      .ld_addr      (ld_addr),
      .drain_ack    (drain_ack),
      .drain_vld    (drain_vld),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data),
      .full         (full),
      .empty        (empty),
      .fwd_byteen   (fwd_byteen),
      .fwd_data     (fwd_data)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   initial watch_timeout(OP_COUNT * 20);

   //----------------------------------------------------------------------
   // store encoding as the core sees it
   //----------------------------------------------------------------------
   function automatic logic [BYTE_WIDTH-1:0] store_byteen(access_size_e size,
                                                          logic [ADDR_WIDTH-1:0] addr);
      logic [BYTE_WIDTH-1:0] mask;
      case (size)
         size_byte: mask = 4'h1;
         size_half: mask = 4'h3;
         default:   mask = 4'hf;
      endcase
      return mask << addr[OFFS_WIDTH-1:0];
   endfunction

   function automatic logic [DATA_WIDTH-1:0] lane_mask(logic [BYTE_WIDTH-1:0] byteen);
      logic [DATA_WIDTH-1:0] mask;
      mask = '0;
      for (int i = 0; i < BYTE_WIDTH; i++) begin
         if (byteen[i]) mask[i*8 +: 8] = 8'hff;
      end
      return mask;
   endfunction

   // oldest first, so younger stores overwrite each lane
   task automatic merge_forward(input  logic [ADDR_WIDTH-1:0] addr,
                                output logic [BYTE_WIDTH-1:0] be,
                                output logic [DATA_WIDTH-1:0] data);
      be   = '0;
      data = '0;
      for (int i = 0; i < m_id.size(); i++) begin
         if (m_state[i] != ST_FLUSH &&
             m_addr[i][ADDR_WIDTH-1:OFFS_WIDTH] == addr[ADDR_WIDTH-1:OFFS_WIDTH]) begin
            for (int j = 0; j < BYTE_WIDTH; j++) begin
               if (m_byteen[i][j]) begin
                  be[j]          = 1'b1;
                  data[j*8 +: 8] = m_data[i][j*8 +: 8];
               end
            end
         end
      end
   endtask

   //----------------------------------------------------------------------
   // per-cycle stimulus, checks and model step
   //----------------------------------------------------------------------
   task automatic drive_inputs();
      logic head_ready;
      head_ready = (m_id.size() > 0) && (m_state[0] == ST_COMMIT);
      st_dc3 = st_dc2;
      st_dc2 = st_dc1;
      // start a store only if its slot is certain by dc3
      st_dc1 = traffic_on && (m_id.size() + st_dc2 + st_dc3 < DEPTH) && ($urandom % 2 == 1);
      if (st_dc3) begin
         st_size = access_size_e'($urandom % 3);
         st_addr = 16'h4a00 + 16'($urandom % 16);
         if (st_size == size_half) st_addr[0] = 1'b0;
         if (st_size == size_word) st_addr[1:0] = 2'b00;
         st_data = $urandom;
      end
      commit_dc5 = ($urandom % 4) != 0;      // mostly commits
      ld_dc2     = traffic_on && ($urandom % 2 == 1);
      ld_addr    = 16'h4a00 + 16'($urandom % 20);   // some words never stored
      drain_ack  = head_ready && ($urandom % 3 != 0);
   endtask

   task automatic check_outputs();
      logic head_ready;
      head_ready = (m_id.size() > 0) && (m_state[0] == ST_COMMIT);
      check_value("drain_vld", drain_vld, head_ready);
      check_value("empty", empty, m_id.size() == 0);
      check_value("full", full, (m_id.size() + st_dc1 + st_dc2 + st_dc3) >= DEPTH);
      check_value("model entry count within DEPTH", m_id.size() <= DEPTH, 1'b1);
      if (head_ready) begin
         check_value("drain_addr", drain_addr, m_addr[0]);
         check_value("drain_byteen", drain_byteen, m_byteen[0]);
         check_value("drain_data", drain_data & lane_mask(m_byteen[0]), m_data[0]);
      end
      if (hold_pending) begin
         check_value("drain_addr held", drain_addr, hold_addr);
         check_value("drain_byteen held", drain_byteen, hold_byteen);
         check_value("drain_data held", drain_data, hold_data);
      end
      if (ld_pending) begin
         check_value("fwd_byteen", fwd_byteen, exp_fwd_byteen);
         check_value("fwd_data", fwd_data.word, exp_fwd_data);
      end
   endtask

   // what the coming clock edge does to the buffer
   task automatic advance_model();
      int idx;
      ld_pending = ld_dc2;
      if (ld_dc2) merge_forward(ld_addr, exp_fwd_byteen, exp_fwd_data);
      hold_pending = drain_vld && !drain_ack;
      hold_addr    = drain_addr;
      hold_byteen  = drain_byteen;
      hold_data    = drain_data;
      if (m_id.size() > 0 && (drain_ack || m_state[0] == ST_FLUSH)) begin
         m_id.delete(0);
         m_addr.delete(0);
         m_byteen.delete(0);
         m_data.delete(0);
         m_state.delete(0);
      end
      if (dc5_vld) begin   // commit or flush of the store in dc5
         idx = -1;
         for (int i = 0; i < m_id.size(); i++) begin
            if (m_id[i] == dc5_id) idx = i;
         end
         if (idx < 0) stop_run("a store reached dc5 but is missing from the model");
         else m_state[idx] = commit_dc5 ? ST_COMMIT : ST_FLUSH;
      end
      if (st_dc3) begin
         m_id.push_back(next_id);
         m_addr.push_back(st_addr);
         m_byteen.push_back(store_byteen(st_size, st_addr));
         m_data.push_back((st_data << (8 * st_addr[OFFS_WIDTH-1:0])) &
                          lane_mask(store_byteen(st_size, st_addr)));
         m_state.push_back(ST_PENDING);
      end
      dc5_vld = dc4_vld;
      dc5_id  = dc4_id;
      dc4_vld = st_dc3;
      dc4_id  = next_id;
      if (st_dc3) next_id++;
   endtask

   task automatic run_cycle();
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);   // outputs settled mid-cycle
      check_outputs();
      advance_model();
   endtask

   //----------------------------------------------------------------------
   // main sequence
   //----------------------------------------------------------------------
   initial begin
      void'($urandom(SEED));
      clk          = 1'b0;
      rst_n        = 1'b0;
      st_dc1       = 1'b0;
      st_dc2       = 1'b0;
      st_dc3       = 1'b0;
      st_addr      = '0;
      st_size      = size_byte;
      st_data      = '0;
      commit_dc5   = 1'b0;
      ld_dc2       = 1'b0;
      ld_addr      = '0;
      drain_ack    = 1'b0;
      next_id      = 0;
      dc4_vld      = 1'b0;
      dc4_id       = 0;
      dc5_vld      = 1'b0;
      dc5_id       = 0;
      traffic_on   = 1'b0;
      ld_pending   = 1'b0;
      hold_pending = 1'b0;
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;
      @(negedge clk);
      check_value("drain_vld after reset", drain_vld, 1'b0);
      check_value("full after reset", full, 1'b0);
      check_value("fwd_byteen after reset", fwd_byteen, '0);
      check_value("empty after reset", empty, 1'b1);
      traffic_on = 1'b1;
      repeat (OP_COUNT) run_cycle();
      traffic_on = 1'b0;
      // let every started store resolve and leave
      while (m_id.size() != 0 || st_dc1 || st_dc2 || st_dc3 || dc4_vld || dc5_vld) begin
         run_cycle();
      end
      repeat (2) run_cycle();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: sources.f
+incdir+include
source/stbuf_cfg_pkg.sv
source/stbuf_types_pkg.sv
source/stbuf_write_stage.sv
source/stbuf_resolve_pipe.sv
source/stbuf_entry_array.sv
source/stbuf_load_forward.sv
source/stbuf_top.sv
test/stbuf_tb.sv

// File: run.sh
#!/bin/sh
# build the store buffer testbench with Verilator, run it, judge the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module stbuf_tb \
   -o stbuf_sim || { echo "build failed"; exit 1; }
./obj_dir/stbuf_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
